//--- bench/csrTests.svh
task automatic rwRoundTripTest();
    logic [11:0] addrs [5];
    logic [31:0] data;
    logic [4:0]  uimm;
    int          startErrors;
    startErrors = errorCount;
    addrs = '{addrMscratch, addrMepc, addrMtvec, addrMcause, addrMstatus};
    foreach (addrs[i]) begin
        data = $urandom;
        doCsr(csrWord(F3_RW, addrs[i], 5'd3, 5'd5), data, refRead(addrs[i]), flagsOrdering);
        refWrite(addrs[i], data);
        readCsr(addrs[i], refRead(addrs[i]));
    end
    data = $urandom;   // rd of x0 returns zero
    doCsr(csrWord(F3_RW, addrMscratch, 5'd3, 5'd0), data, 32'd0, flagsOrdering);
    refWrite(addrMscratch, data);
    readCsr(addrMscratch, refRead(addrMscratch));
    uimm = 5'($urandom);   // immediate form writes the zero-extended field
    doCsr(csrWord(F3_RWI, addrMcause, uimm, 5'd1), $urandom, refRead(addrMcause),
          flagsOrdering);
    refWrite(addrMcause, {27'd0, uimm});
    readCsr(addrMcause, refRead(addrMcause));
    finishTest("read-write round trip", startErrors);
endtask

task automatic setClearTest();
    logic [31:0] data;
    logic [4:0]  uimm;
    int          startErrors;
    startErrors = errorCount;
    data = $urandom;
    doCsr(csrWord(F3_RS, addrMscratch, 5'd7, 5'd1), data, refRead(addrMscratch), flagsOrdering);
    refWrite(addrMscratch, refRead(addrMscratch) | data);
    data = $urandom;
    doCsr(csrWord(F3_RC, addrMscratch, 5'd7, 5'd1), data, refRead(addrMscratch), flagsOrdering);
    refWrite(addrMscratch, refRead(addrMscratch) & ~data);
    uimm = 5'(($urandom % 31) + 1);   // nonzero immediates
    doCsr(csrWord(F3_RSI, addrMscratch, uimm, 5'd1), $urandom, refRead(addrMscratch),
          flagsOrdering);
    refWrite(addrMscratch, refRead(addrMscratch) | {27'd0, uimm});
    uimm = 5'(($urandom % 31) + 1);
    doCsr(csrWord(F3_RCI, addrMscratch, uimm, 5'd1), $urandom, refRead(addrMscratch),
          flagsOrdering);
    refWrite(addrMscratch, refRead(addrMscratch) & ~{27'd0, uimm});
    // zero rs1 or uimm turns set and clear into reads
    doCsr(csrWord(F3_RS, addrMscratch, 5'd0, 5'd1), $urandom, refRead(addrMscratch), flagsNone);
    doCsr(csrWord(F3_RC, addrMscratch, 5'd0, 5'd1), $urandom, refRead(addrMscratch), flagsNone);
    doCsr(csrWord(F3_RSI, addrMscratch, 5'd0, 5'd1), $urandom, refRead(addrMscratch), flagsNone);
    doCsr(csrWord(F3_RCI, addrMscratch, 5'd0, 5'd1), $urandom, refRead(addrMscratch), flagsNone);
    readCsr(addrMscratch, refRead(addrMscratch));
    finishTest("set and clear", startErrors);
endtask

task automatic identityTest();
    logic [11:0] ids [4];
    logic [31:0] word;
    int          startErrors;
    startErrors = errorCount;
    ids = '{addrMisa, addrMarchid, addrMimpid, addrMhartid};
    foreach (ids[i]) begin
        readCsr(ids[i], refRead(ids[i]));
        doCsr(csrWord(F3_RW, ids[i], 5'd4, 5'd1), $urandom, 32'd0, flagsIllegal);
        doCsr(csrWord(F3_RSI, ids[i], 5'd9, 5'd1), $urandom, 32'd0, flagsIllegal);
        readCsr(ids[i], refRead(ids[i]));
    end
    doCsr(csrWord(F3_RS, 12'h7C0, 5'd0, 5'd1), $urandom, 32'd0, flagsIllegal);
    doCsr(csrWord(F3_RW, 12'h7C0, 5'd2, 5'd1), $urandom, 32'd0, flagsIllegal);
    word = csrWord(F3_RW, addrMscratch, 5'd1, 5'd1);
    word[6:0] = 7'b0110011;   // OP major opcode, not SYSTEM
    doCsr(word, $urandom, 32'd0, flagsIllegal);
    doCsr(csrWord(3'b000, addrMscratch, 5'd1, 5'd1), $urandom, 32'd0, flagsIllegal);
    doCsr(csrWord(3'b100, addrMscratch, 5'd1, 5'd1), $urandom, 32'd0, flagsIllegal);
    readCsr(addrMscratch, refRead(addrMscratch));
    finishTest("identity and illegal", startErrors);
endtask

task automatic counterTest();
    logic [31:0] hi;
    logic [31:0] lo;
    int          pulses;
    int          startErrors;
    startErrors = errorCount;
    hi = $urandom;
    lo = $urandom & 32'h0fff_ffff;   // no carry into the high half
    doCsr(csrWord(F3_RW, addrMcycleh, 5'd1, 5'd0), hi, 32'd0, flagsOrdering);
    doCsr(csrWord(F3_RW, addrMcycle, 5'd1, 5'd0), lo, 32'd0, flagsOrdering);
    // read is consumed ISSUE_CYCLES edges after the write
    readCsr(addrMcycle, lo + 32'(ISSUE_CYCLES - 1));
    readCsr(addrMcycleh, hi);
    hi = $urandom;
    lo = $urandom & 32'h0fff_ffff;
    doCsr(csrWord(F3_RW, addrMinstreth, 5'd1, 5'd0), hi, 32'd0, flagsOrdering);
    doCsr(csrWord(F3_RW, addrMinstret, 5'd1, 5'd0), lo, 32'd0, flagsOrdering);
    pulses = 3 + int'($urandom % 8);
    repeat (pulses) begin
        @(posedge clk);
        retire <= 1'b1;
        @(posedge clk);
        retire <= 1'b0;
    end
    readCsr(addrMinstret, lo + 32'(pulses));
    readCsr(addrMinstreth, hi);
    finishTest("counters", startErrors);
endtask

task automatic squashStallTest();
    logic [31:0] data;
    int          startErrors;
    startErrors = errorCount;
    data = $urandom;   // branch one older than the op
    issue(csrWord(F3_RW, addrMscratch, 5'd1, 5'd1), data, 0, 1'b1, SQN_WIDTH'(1));
    if (seen) begin
        errorCount++;
        $display("error at %0t: squashed op sqN %0d produced a result", $time, issSqN);
    end
    readCsr(addrMscratch, refRead(addrMscratch));
    data = $urandom;   // same sqN as the branch
    issue(csrWord(F3_RW, addrMepc, 5'd1, 5'd1), data, 0, 1'b1, SQN_WIDTH'(0));
    checkResult(refRead(addrMepc), flagsOrdering);
    refWrite(addrMepc, data);
    data = $urandom;   // branch younger than the op
    issue(csrWord(F3_RW, addrMcause, 5'd1, 5'd1), data, 0, 1'b1, SQN_WIDTH'(-2));
    checkResult(refRead(addrMcause), flagsOrdering);
    refWrite(addrMcause, data);
    data = $urandom;
    issue(csrWord(F3_RW, addrMscratch, 5'd1, 5'd1), data, 5, 1'b0, SQN_WIDTH'(0));
    checkResult(refRead(addrMscratch), flagsOrdering);
    refWrite(addrMscratch, data);
    readCsr(addrMepc, refRead(addrMepc));
    readCsr(addrMcause, refRead(addrMcause));
    readCsr(addrMscratch, refRead(addrMscratch));
    finishTest("squash and stall", startErrors);
endtask

//--- bench/csrUnitTb.sv
`default_nettype none

module csrUnitTb import csrPkg::*; ();

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int RES_WAIT     = 8;    // cycles to wait for resValid
    localparam int ISSUE_CYCLES = 3;    // consume distance of back-to-back ops
    localparam int MAX_STALL    = 8;
    localparam int MAX_ISSUES   = 90;
    localparam int MAX_PULSES   = 10;   // retire pulses in the counter test
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_ISSUES * (3 + RES_WAIT + MAX_STALL)
                                     + 2 * MAX_PULSES + 100;

    // funct3 encodings of the CSR instructions
    localparam logic [2:0] F3_RW  = 3'b001;
    localparam logic [2:0] F3_RS  = 3'b010;
    localparam logic [2:0] F3_RC  = 3'b011;
    localparam logic [2:0] F3_RWI = 3'b101;
    localparam logic [2:0] F3_RSI = 3'b110;
    localparam logic [2:0] F3_RCI = 3'b111;

    logic                 clk;
    logic                 rst;
    logic                 en;
    logic                 instrValid;
    logic [31:0]          instr;
    logic [31:0]          srcA;
    logic [31:0]          pc;
    logic [SQN_WIDTH-1:0] sqN;
    logic [TAG_WIDTH-1:0] tagDst;
    logic                 branchTaken;
    logic [SQN_WIDTH-1:0] branchSqN;
    logic                 retire;
    logic                 resValid;
    logic [31:0]          result;
    logic [31:0]          resPc;
    logic [SQN_WIDTH-1:0] resSqN;
    logic [TAG_WIDTH-1:0] resTagDst;
    resFlagsE             resFlags;

    int          errorCount;
    int          testCount;
    int          failedTests;
    int unsigned seedValue;

    logic [SQN_WIDTH-1:0] nextSqN;
    logic [31:0]          nextPc;
    logic [SQN_WIDTH-1:0] issSqN;   // fields of the op in flight
    logic [TAG_WIDTH-1:0] issTag;
    logic [31:0]          issPc;

    logic                 seen;     // captured result
    int                   latency;
    logic [31:0]          capResult;
    logic [31:0]          capPc;
    logic [SQN_WIDTH-1:0] capSqN;
    logic [TAG_WIDTH-1:0] capTag;
    resFlagsE             capFlags;

    // expected machine registers
    logic [31:0] refMstatus;
    logic [31:0] refMtvec;
    logic [31:0] refMscratch;
    logic [31:0] refMepc;
    logic [31:0] refMcause;

    csrUnit u_csrUnit (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .instrValid  (instrValid),
        .instr       (instr),
        .srcA        (srcA),
        .pc          (pc),
        .sqN         (sqN),
        .tagDst      (tagDst),
        .branchTaken (branchTaken),
        .branchSqN   (branchSqN),
        .retire      (retire),
        .resValid    (resValid),
        .result      (result),
        .resPc       (resPc),
        .resSqN      (resSqN),
        .resTagDst   (resTagDst),
        .resFlags    (resFlags)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] csrWord(input logic [2:0] f3, input logic [11:0] addr,
                                            input logic [4:0] rs1, input logic [4:0] rd);
        return {addr, rs1, f3, rd, 7'b1110011};
    endfunction

    function automatic logic [31:0] refRead(input logic [11:0] addr);
        case (addr)
            addrMstatus:  return refMstatus;
            addrMtvec:    return refMtvec;
            addrMscratch: return refMscratch;
            addrMepc:     return refMepc;
            addrMcause:   return refMcause;
            addrMisa:     return MISA_VALUE;
            addrMarchid:  return MARCHID_VALUE;
            addrMimpid:   return MIMPID_VALUE;
            default:      return 32'd0;   // mhartid and unknown addresses
        endcase
    endfunction

    function automatic void refWrite(input logic [11:0] addr, input logic [31:0] value);
        case (addr)
            addrMstatus:  refMstatus  = value & 32'h0000_1888;   // MIE, MPIE, MPP
            addrMtvec:    refMtvec    = {value[31:2], 1'b0, value[0]};
            addrMscratch: refMscratch = value;
            addrMepc:     refMepc     = {value[31:1], 1'b0};
            addrMcause:   refMcause   = value;
            default: ;
        endcase
    endfunction

    task automatic expectEq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // one op through the pipe, optionally stalled or hit by a branch
    task automatic issue(input logic [31:0] word, input logic [31:0] data, input int stall,
                         input logic brTaken, input logic [SQN_WIDTH-1:0] brDelta);
        int waited;
        @(posedge clk);
        issSqN = nextSqN;
        issTag = TAG_WIDTH'($urandom);
        issPc  = nextPc;
        instrValid  <= 1'b1;
        instr       <= word;
        srcA        <= data;
        pc          <= issPc;
        sqN         <= issSqN;
        tagDst      <= issTag;
        branchTaken <= 1'b0;
        nextSqN = nextSqN + SQN_WIDTH'(1);
        nextPc  = nextPc + 32'd4;
        @(posedge clk);   // accept edge
        instrValid  <= 1'b0;
        branchTaken <= brTaken;
        branchSqN   <= issSqN - brDelta;
        if (stall > 0) begin
            en <= 1'b0;
            repeat (stall) begin
                @(negedge clk);
                if (resValid) begin
                    errorCount++;
                    $display("error at %0t: result appeared while en was low", $time);
                end
            end
            @(posedge clk);
            en <= 1'b1;
        end
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < RES_WAIT) begin
            @(negedge clk);
            waited++;
            if (resValid) begin
                seen      = 1'b1;
                latency   = waited;
                capResult = result;
                capFlags  = resFlags;
                capSqN    = resSqN;
                capTag    = resTagDst;
                capPc     = resPc;
            end
        end
    endtask

    task automatic checkResult(input logic [31:0] expRes, input resFlagsE expFlags);
        if (!seen) begin
            errorCount++;
            $display("error at %0t: no result for sqN %0d within %0d cycles",
                     $time, issSqN, RES_WAIT);
        end else begin
            expectEq("result", expRes, capResult);
            expectEq("resFlags", 32'(expFlags), 32'(capFlags));
            expectEq("resSqN", 32'(issSqN), 32'(capSqN));
            expectEq("resTagDst", 32'(issTag), 32'(capTag));
            expectEq("resPc", issPc, capPc);
            if (latency != 2) begin
                errorCount++;
                $display("error at %0t: result came %0d cycles after acceptance, not 2",
                         $time, latency);
            end
        end
    endtask

    task automatic doCsr(input logic [31:0] word, input logic [31:0] data,
                         input logic [31:0] expRes, input resFlagsE expFlags);
        issue(word, data, 0, 1'b0, '0);
        checkResult(expRes, expFlags);
    endtask

    // csrrs with rs1 zero is a pure read
    task automatic readCsr(input logic [11:0] addr, input logic [31:0] expected);
        doCsr(csrWord(F3_RS, addr, 5'd0, 5'd1), $urandom, expected, flagsNone);
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", name, errorCount - startErrors);
        end
    endtask

`include "csrTests.svh"

    initial begin
        seedValue   = $urandom(32'h2744fb23);
        clk         = 1'b0;
        rst         = 1'b1;
        en          = 1'b1;
        instrValid  = 1'b0;
        instr       = 32'd0;
        srcA        = 32'd0;
        pc          = 32'd0;
        sqN         = '0;
        tagDst      = '0;
        branchTaken = 1'b0;
        branchSqN   = '0;
        retire      = 1'b0;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        refMstatus  = 32'd0;
        refMtvec    = 32'd0;
        refMscratch = 32'd0;
        refMepc     = 32'd0;
        refMcause   = 32'd0;
        nextSqN     = SQN_WIDTH'(50);   // wraps during the run
        nextPc      = 32'h0000_1000;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (resValid !== 1'b0) begin
            errorCount++;
            $display("error at %0t: resValid expected 0, got %b", $time, resValid);
        end
        rwRoundTripTest();
        setClearTest();
        identityTest();
        counterTest();
        squashStallTest();
        $display("tests run %0d, tests failing %0d, errors %0d",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the CSR unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f --top-module csrUnitTb -o csrUnitSim; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/csrUnitSim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

//--- source/csrCounters.sv
`default_nettype none

module csrCounters import csrPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      retire,
    csrCntIf.counters cnt
);

    logic [63:0] cycleQ;
    logic [63:0] instretQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycleQ   <= '0;
            instretQ <= '0;
        end else begin
            cycleQ <= cycleQ + 64'd1;   // free running
            if (retire) begin
                instretQ <= instretQ + 64'd1;
            end

            // a written counter skips this cycle's increment
            if (cnt.wrEn) begin
                case (cnt.wrSel)
                    selCycleLo: begin
                        cycleQ <= {cycleQ[63:32], cnt.wrData};
                    end
                    selCycleHi: begin
                        cycleQ <= {cnt.wrData, cycleQ[31:0]};
                    end
                    selInstretLo: begin
                        instretQ <= {instretQ[63:32], cnt.wrData};
                    end
                    selInstretHi: begin
                        instretQ <= {cnt.wrData, instretQ[31:0]};
                    end
                endcase
            end
        end
    end

    assign cnt.mcycle   = cycleQ;
    assign cnt.minstret = instretQ;

    // execute must not issue a counter write while the core is in reset
    noWriteInReset: assert property (@(posedge clk) rst |-> !cnt.wrEn);

endmodule

`default_nettype wire

//--- source/csrDecode.sv
`default_nettype none

module csrDecode import csrPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en,
    input  logic                 instrValid,
    input  logic [31:0]          instr,
    input  logic [31:0]          srcA,
    input  logic [31:0]          pc,
    input  logic [SQN_WIDTH-1:0] sqN,
    input  logic [TAG_WIDTH-1:0] tagDst,
    csrUopIf.decode              uop
);

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic [4:0] rs1;     // register index or uimm
    logic       badFunct;
    logic       isRw;
    csrOpE      opNext;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];

    always_comb begin
        badFunct = 1'b0;
        case (funct3)
            3'b001: opNext = csrRW;
            3'b010: opNext = csrRS;
            3'b011: opNext = csrRC;
            3'b101: opNext = csrRWI;
            3'b110: opNext = csrRSI;
            3'b111: opNext = csrRCI;
            default: begin   // ecall/ebreak space and reserved
                opNext   = csrRW;
                badFunct = 1'b1;
            end
        endcase
    end

    assign isRw = (opNext == csrRW) || (opNext == csrRWI);

    always_ff @(posedge clk) begin
        if (rst) begin
            uop.valid <= 1'b0;
        end else if (en) begin
            uop.valid <= instrValid;
            if (instrValid) begin
                uop.op      <= opNext;
                uop.addr    <= instr[31:20];
                uop.uimm    <= rs1;
                uop.srcA    <= srcA;
                uop.doRead  <= !isRw || (rd != 5'd0);   // rw to x0 skips the read
                uop.doWrite <= isRw || (rs1 != 5'd0);   // set/clear with zero is read only
                uop.illegal <= badFunct || (opcode != OPC_SYSTEM);
                uop.pc      <= pc;
                uop.sqN     <= sqN;
                uop.tagDst  <= tagDst;
            end
        end
    end

    // a legal micro-op handed to execute always carries a real operation
    opKnown: assert property (@(posedge clk) disable iff (rst)
        uop.valid && !uop.illegal |->
            uop.op inside {csrRW, csrRS, csrRC, csrRWI, csrRSI, csrRCI});

endmodule

`default_nettype wire

//--- source/csrExecute.sv
`default_nettype none

module csrExecute import csrPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en,
    input  logic                 branchTaken,
    input  logic [SQN_WIDTH-1:0] branchSqN,
    csrUopIf.execute             uop,
    csrCntIf.execute             cnt,
    output logic                 resValid,
    output logic [31:0]          result,
    output logic [31:0]          resPc,
    output logic [SQN_WIDTH-1:0] resSqN,
    output logic [TAG_WIDTH-1:0] resTagDst,
    output resFlagsE             resFlags
);

    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;

    logic signed [SQN_WIDTH-1:0] sqnDiff;
    logic        squash;
    logic        fire;          // valid, enabled and not squashed
    logic        known;
    logic        readOnly;
    logic        isCounter;
    cntSelE      cntSel;
    logic [31:0] oldVal;
    logic [31:0] src;
    logic [31:0] wdata;
    logic        badAccess;
    logic        doWr;

    // wrapping sequence compare, positive means younger than the branch
    assign sqnDiff = uop.sqN - branchSqN;
    assign squash  = branchTaken && (sqnDiff > 0);
    assign fire    = en && uop.valid && !squash;

    always_comb begin
        known     = 1'b1;
        readOnly  = 1'b0;
        isCounter = 1'b0;
        cntSel    = selCycleLo;
        oldVal    = '0;
        case (uop.addr)
            addrMstatus:  oldVal = mstatus;
            addrMtvec:    oldVal = mtvec;
            addrMscratch: oldVal = mscratch;
            addrMepc:     oldVal = mepc;
            addrMcause:   oldVal = mcause;
            addrMcycle: begin
                oldVal    = cnt.mcycle[31:0];
                isCounter = 1'b1;
                cntSel    = selCycleLo;
            end
            addrMcycleh: begin
                oldVal    = cnt.mcycle[63:32];
                isCounter = 1'b1;
                cntSel    = selCycleHi;
            end
            addrMinstret: begin
                oldVal    = cnt.minstret[31:0];
                isCounter = 1'b1;
                cntSel    = selInstretLo;
            end
            addrMinstreth: begin
                oldVal    = cnt.minstret[63:32];
                isCounter = 1'b1;
                cntSel    = selInstretHi;
            end
            addrMisa: begin
                oldVal   = MISA_VALUE;
                readOnly = 1'b1;
            end
            addrMarchid: begin
                oldVal   = MARCHID_VALUE;
                readOnly = 1'b1;
            end
            addrMimpid: begin
                oldVal   = MIMPID_VALUE;
                readOnly = 1'b1;
            end
            addrMhartid: readOnly = 1'b1;   // single hart, reads zero
            default:     known    = 1'b0;
        endcase
    end

    assign src = (uop.op == csrRWI || uop.op == csrRSI || uop.op == csrRCI) ?
                 {27'd0, uop.uimm} : uop.srcA;

    always_comb begin
        case (uop.op)
            csrRS, csrRSI: wdata = oldVal | src;
            csrRC, csrRCI: wdata = oldVal & ~src;
            default:       wdata = src;
        endcase
    end

    assign badAccess = uop.illegal || !known || (readOnly && uop.doWrite);
    assign doWr      = fire && uop.doWrite && !badAccess;

    assign cnt.wrEn   = doWr && isCounter;
    assign cnt.wrSel  = cntSel;
    assign cnt.wrData = wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (doWr) begin
            case (uop.addr)
                addrMstatus:  mstatus  <= wdata & MSTATUS_WMASK;
                addrMtvec:    mtvec    <= {wdata[31:2], 1'b0, wdata[0]};  // modes 0/1 only
                addrMscratch: mscratch <= wdata;
                addrMepc:     mepc     <= {wdata[31:1], 1'b0};
                addrMcause:   mcause   <= wdata;
                default: ;  // counter halves written via cnt
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            result    <= (uop.doRead && !badAccess) ? oldVal : 32'd0;
            resPc     <= uop.pc;
            resSqN    <= uop.sqN;
            resTagDst <= uop.tagDst;
            if (badAccess) begin
                resFlags <= flagsIllegal;
            end else if (uop.doWrite) begin
                resFlags <= flagsOrdering;   // later ops must see the new value
            end else begin
                resFlags <= flagsNone;
            end
        end
    end

    resetDrop: assert property (@(posedge clk) rst |=> !resValid);

    // a counter write belongs to a live write that reports ordering next cycle
    counterWriteLive: assert property (@(posedge clk) disable iff (rst)
        cnt.wrEn |=> resValid && resFlags == flagsOrdering);

endmodule

`default_nettype wire

//--- source/csrIf.sv
`default_nettype none

// decoded micro-op, decode register to execute
interface csrUopIf import csrPkg::*; ();
    logic                 valid;
    csrOpE                op;
    logic [11:0]          addr;     // raw csr field, may be unimplemented
    logic [4:0]           uimm;
    logic [31:0]          srcA;
    logic                 doRead;
    logic                 doWrite;
    logic                 illegal;
    logic [31:0]          pc;
    logic [SQN_WIDTH-1:0] sqN;
    logic [TAG_WIDTH-1:0] tagDst;

    modport decode (
        output valid, op, addr, uimm, srcA, doRead, doWrite, illegal,
        output pc, sqN, tagDst
    );

    modport execute (
        input valid, op, addr, uimm, srcA, doRead, doWrite, illegal,
        input pc, sqN, tagDst
    );
endinterface

// counter write port and counter values
interface csrCntIf import csrPkg::*; ();
    logic        wrEn;
    cntSelE      wrSel;
    logic [31:0] wrData;
    logic [63:0] mcycle;
    logic [63:0] minstret;

    modport execute (
        output wrEn, wrSel, wrData,
        input  mcycle, minstret
    );

    modport counters (
        input  wrEn, wrSel, wrData,
        output mcycle, minstret
    );
endinterface

`default_nettype wire

//--- source/csrPkg.sv
`default_nettype none

package csrPkg;

    localparam int SQN_WIDTH = 6;   // sequence number width
    localparam int TAG_WIDTH = 6;   // destination tag width

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // identity values for the read-only machine registers
    localparam logic [31:0] MISA_VALUE    = 32'h4000_1100; // rv32, I and M
    localparam logic [31:0] MARCHID_VALUE = 32'h0000_0017;
    localparam logic [31:0] MIMPID_VALUE  = 32'h0000_0102;

    // MPP (12:11), MPIE (7), MIE (3)
    localparam logic [31:0] MSTATUS_WMASK = 32'h0000_1888;

    // CSR operations, decoded from funct3
    typedef enum logic [2:0] {
        csrRW  = 3'd0,
        csrRS  = 3'd1,
        csrRC  = 3'd2,
        csrRWI = 3'd3,
        csrRSI = 3'd4,
        csrRCI = 3'd5
    } csrOpE;

    // implemented CSR addresses, standard numbering
    typedef enum logic [11:0] {
        addrMstatus  = 12'h300,
        addrMisa     = 12'h301,
        addrMtvec    = 12'h305,
        addrMscratch = 12'h340,
        addrMepc     = 12'h341,
        addrMcause   = 12'h342,
        addrMcycle   = 12'hB00,
        addrMinstret = 12'hB02,
        addrMcycleh  = 12'hB80,
        addrMinstreth = 12'hB82,
        addrMarchid  = 12'hF12,
        addrMimpid   = 12'hF13,
        addrMhartid  = 12'hF14
    } csrAddrE;

    // result flags handed back to the core
    typedef enum logic [1:0] {
        flagsNone     = 2'd0,
        flagsOrdering = 2'd1,
        flagsIllegal  = 2'd2
    } resFlagsE;

    // counter half selected by a write
    typedef enum logic [1:0] {
        selCycleLo   = 2'd0,
        selCycleHi   = 2'd1,
        selInstretLo = 2'd2,
        selInstretHi = 2'd3
    } cntSelE;

endpackage

`default_nettype wire

//--- source/csrUnit.sv
`default_nettype none

module csrUnit import csrPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en,
    input  logic                 instrValid,
    input  logic [31:0]          instr,
    input  logic [31:0]          srcA,
    input  logic [31:0]          pc,
    input  logic [SQN_WIDTH-1:0] sqN,
    input  logic [TAG_WIDTH-1:0] tagDst,
    input  logic                 branchTaken,
    input  logic [SQN_WIDTH-1:0] branchSqN,
    input  logic                 retire,
    output logic                 resValid,
    output logic [31:0]          result,
    output logic [31:0]          resPc,
    output logic [SQN_WIDTH-1:0] resSqN,
    output logic [TAG_WIDTH-1:0] resTagDst,
    output resFlagsE             resFlags
);

    csrUopIf uopBus ();   // decode register to execute
    csrCntIf cntBus ();   // execute to counters

    csrDecode u_decode (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .instrValid (instrValid),
        .instr      (instr),
        .srcA       (srcA),
        .pc         (pc),
        .sqN        (sqN),
        .tagDst     (tagDst),
        .uop        (uopBus.decode)
    );

    csrExecute u_execute (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .branchTaken (branchTaken),
        .branchSqN   (branchSqN),
        .uop         (uopBus.execute),
        .cnt         (cntBus.execute),
        .resValid    (resValid),
        .result      (result),
        .resPc       (resPc),
        .resSqN      (resSqN),
        .resTagDst   (resTagDst),
        .resFlags    (resFlags)
    );

    csrCounters u_counters (
        .clk    (clk),
        .rst    (rst),
        .retire (retire),
        .cnt    (cntBus.counters)
    );

endmodule

`default_nettype wire

//--- verilog.f
+incdir+bench
source/csrPkg.sv
source/csrIf.sv
source/csrDecode.sv
source/csrCounters.sv
source/csrExecute.sv
source/csrUnit.sv
bench/csrUnitTb.sv
